// File: source/dport_pkg.sv
package dport_pkg;

    // Fixed attributes of every beat on the bus.
    localparam logic [3:0] AXI_ID         = 4'd1;
    localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } dport_op_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2
    } axi_resp_e;

    // Core side request and response.
    typedef struct packed {
        dport_op_e   op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
    } dport_req_t;

    typedef struct packed {
        dport_op_e   op;
        logic [31:0] rdata;
        axi_resp_e   resp;
    } dport_rsp_t;

    // Address channel, shared by writes and reads.
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        axi_resp_e  resp;
    } axi_b_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
    } axi_r_t;

endpackage

// File: source/data_req_queue.sv
module data_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 axi4_master,
    input  logic                 arst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  dport_pkg::dport_req_t req,
    output logic                 q_valid,
    input  logic                 q_ready,
    output dport_pkg::dport_req_t q_req
);

    import dport_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    dport_req_t       entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(QUEUE_DEPTH));

    // A full queue still takes a request when the head leaves this cycle.
    assign req_ready = !full || q_ready;
    assign q_valid   = (count != '0);
    assign q_req     = entries[rd_ptr];

    assign push = req_valid && req_ready;
    assign pop  = q_valid && q_ready;

    always_ff @(posedge axi4_master) begin
        if (push) begin
            entries[wr_ptr] <= req;
        end
    end

    always_ff @(posedge axi4_master or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Count moves only when one side acts alone.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: source/axi4_master_data.sv
module axi4_master_data (
    input  logic                  axi4_master,
    input  logic                  arst_n,
    input  logic                  q_valid,
    output logic                  q_ready,
    input  dport_pkg::dport_req_t q_req,
    output logic                  awvalid,
    input  logic                  awready,
    output dport_pkg::axi_aw_t    aw,
    output logic                  wvalid,
    input  logic                  wready,
    output dport_pkg::axi_w_t     w,
    input  logic                  bvalid,
    output logic                  bready,
    input  dport_pkg::axi_b_t     b,
    output logic                  arvalid,
    input  logic                  arready,
    output dport_pkg::axi_ar_t    ar,
    input  logic                  rvalid,
    output logic                  rready,
    input  dport_pkg::axi_r_t     r,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output dport_pkg::dport_rsp_t rsp
);

    import dport_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_waddr,
        st_wdata,
        st_wresp,
        st_raddr,
        st_rdata,
        st_respond
    } state_e;

    state_e     state;
    dport_req_t req_q;
    dport_rsp_t rsp_q;
    logic       take;
    logic       b_done;
    logic       r_done;
    axi_resp_e  b_code;
    axi_resp_e  r_code;

    // Only one transaction in flight, so the queue is popped from idle only.
    assign q_ready = (state == st_idle);
    assign take    = q_valid && q_ready;

    assign awvalid   = (state == st_waddr);
    assign wvalid    = (state == st_wdata);
    assign bready    = (state == st_wresp);
    assign arvalid   = (state == st_raddr);
    assign rready    = (state == st_rdata);
    assign rsp_valid = (state == st_respond);

    assign b_done = bvalid && bready;
    assign r_done = rvalid && rready;

    // Single beat, word size, incrementing.
    always_comb begin
        aw.id    = AXI_ID;
        aw.addr  = req_q.addr;
        aw.len   = AXI_LEN_SINGLE;
        aw.size  = AXI_SIZE_WORD;
        aw.burst = AXI_BURST_INCR;
        ar       = aw;
    end

    assign w.data = req_q.wdata;
    assign w.strb = req_q.mask;
    assign w.last = 1'b1;

    // A reply with a foreign id or a missing last is treated as a slave error.
    assign b_code = (b.id != AXI_ID) ? resp_slverr : b.resp;
    assign r_code = (r.id != AXI_ID || !r.last) ? resp_slverr : r.resp;

    assign rsp = rsp_q;

    always_ff @(posedge axi4_master) begin
        if (take) begin
            req_q <= q_req;
        end
        if (b_done) begin
            rsp_q.op    <= req_q.op;
            rsp_q.rdata <= '0;
            rsp_q.resp  <= b_code;
        end
        if (r_done) begin
            rsp_q.op    <= req_q.op;
            rsp_q.rdata <= r.data;
            rsp_q.resp  <= r_code;
        end
    end

    always_ff @(posedge axi4_master or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (take) begin
                        if (q_req.op == op_write) begin
                            state <= st_waddr;
                        end else begin
                            state <= st_raddr;
                        end
                    end
                end
                st_waddr: begin
                    if (awready) begin
                        state <= st_wdata;
                    end
                end
                st_wdata: begin
                    if (wready) begin
                        state <= st_wresp;
                    end
                end
                st_wresp: begin
                    if (b_done) begin
                        state <= st_respond;
                    end
                end
                st_raddr: begin
                    if (arready) begin
                        state <= st_rdata;
                    end
                end
                st_rdata: begin
                    if (r_done) begin
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    // Hold the result until the core takes it.
                    if (rsp_ready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: source/axi4_sram_slave.sv
module axi4_sram_slave #(
    parameter int MEM_WORDS = 256
) (
    input  logic               axi4_master,
    input  logic               arst_n,
    input  logic               awvalid,
    output logic               awready,
    input  dport_pkg::axi_aw_t aw,
    input  logic               wvalid,
    output logic               wready,
    input  dport_pkg::axi_w_t  w,
    output logic               bvalid,
    input  logic               bready,
    output dport_pkg::axi_b_t  b,
    input  logic               arvalid,
    output logic               arready,
    input  dport_pkg::axi_ar_t ar,
    output logic               rvalid,
    input  logic               rready,
    output dport_pkg::axi_r_t  r
);

    import dport_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {
        ss_idle,
        ss_wdata,
        ss_wresp,
        ss_rdata
    } slave_state_e;

    slave_state_e state;
    logic [31:0]  mem [MEM_WORDS];
    logic [3:0]   id_q;
    logic [IDX_W-1:0] idx_q;
    logic         err_q;
    logic [31:0]  rdata_q;
    logic         aw_hs;
    logic         w_hs;
    logic         ar_hs;

    // Out of range or unexpected attributes both give a slave error.
    function automatic logic addr_err(input axi_aw_t a);
        logic bad;
        bad = (a.addr[31:2] >= 30'(MEM_WORDS));
        bad = bad || (a.id != AXI_ID) || (a.len != AXI_LEN_SINGLE);
        bad = bad || (a.size != AXI_SIZE_WORD) || (a.burst != AXI_BURST_INCR);
        return bad;
    endfunction

    // Writes win when both address channels are valid.
    assign awready = (state == ss_idle);
    assign arready = (state == ss_idle) && !awvalid;
    assign wready  = (state == ss_wdata);
    assign bvalid  = (state == ss_wresp);
    assign rvalid  = (state == ss_rdata);

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;

    assign b.id   = id_q;
    assign b.resp = err_q ? resp_slverr : resp_okay;

    assign r.id   = id_q;
    assign r.data = rdata_q;
    assign r.resp = err_q ? resp_slverr : resp_okay;
    assign r.last = 1'b1;

    always_ff @(posedge axi4_master) begin
        if (aw_hs) begin
            id_q  <= aw.id;
            idx_q <= aw.addr[IDX_W+1:2];
            err_q <= addr_err(aw);
        end
        if (ar_hs) begin
            id_q  <= ar.id;
            err_q <= addr_err(ar);
            // Rejected reads return zero data.
            if (addr_err(ar)) begin
                rdata_q <= '0;
            end else begin
                rdata_q <= mem[ar.addr[IDX_W+1:2]];
            end
        end
    end

    always_ff @(posedge axi4_master or negedge arst_n) begin
        if (!arst_n) begin
            state <= ss_idle;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                ss_idle: begin
                    if (aw_hs) begin
                        state <= ss_wdata;
                    end else if (ar_hs) begin
                        state <= ss_rdata;
                    end
                end
                ss_wdata: begin
                    if (w_hs) begin
                        // Strobed bytes only.
                        if (!err_q) begin
                            for (int i = 0; i < 4; i++) begin
                                if (w.strb[i]) begin
                                    mem[idx_q][8*i +: 8] <= w.data[8*i +: 8];
                                end
                            end
                        end
                        state <= ss_wresp;
                    end
                end
                ss_wresp: begin
                    if (bready) begin
                        state <= ss_idle;
                    end
                end
                ss_rdata: begin
                    if (rready) begin
                        state <= ss_idle;
                    end
                end
                default: begin
                    state <= ss_idle;
                end
            endcase
        end
    end

endmodule

// File: source/dport_axi_top.sv
module dport_axi_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256
) (
    input  logic                  axi4_master,
    input  logic                  arst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  dport_pkg::dport_req_t req,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output dport_pkg::dport_rsp_t rsp
);

    import dport_pkg::*;

    logic       q_valid;
    logic       q_ready;
    dport_req_t q_req;

    // AXI wires between master and memory.
    logic    awvalid;
    logic    awready;
    axi_aw_t aw;
    logic    wvalid;
    logic    wready;
    axi_w_t  w;
    logic    bvalid;
    logic    bready;
    axi_b_t  b;
    logic    arvalid;
    logic    arready;
    axi_ar_t ar;
    logic    rvalid;
    logic    rready;
    axi_r_t  r;

    data_req_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_queue (
        .axi4_master(axi4_master),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .q_req      (q_req)
    );

    axi4_master_data i_master (
        .axi4_master(axi4_master),
        .arst_n     (arst_n),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .q_req      (q_req),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .b          (b),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp)
    );

    axi4_sram_slave #(
        .MEM_WORDS(MEM_WORDS)
    ) i_slave (
        .axi4_master(axi4_master),
        .arst_n     (arst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .b          (b),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r)
    );

endmodule

// File: sim/dport_axi_assertions.sv
module dport_axi_assertions (
    input logic                  axi4_master,
    input logic                  arst_n,
    input logic                  awvalid,
    input logic                  awready,
    input dport_pkg::axi_aw_t    aw,
    input logic                  wvalid,
    input logic                  wready,
    input dport_pkg::axi_w_t     w,
    input logic                  arvalid,
    input logic                  arready,
    input dport_pkg::axi_ar_t    ar,
    input logic                  bvalid,
    input logic                  bready,
    input logic                  rvalid,
    input logic                  rready,
    input logic                  rsp_valid,
    input logic                  rsp_ready,
    input dport_pkg::dport_rsp_t rsp
);

    logic w_pending;
    logic r_pending;

    // Address accepted, reply not yet taken.
    always_ff @(posedge axi4_master or negedge arst_n) begin
        if (!arst_n) begin
            w_pending <= 1'b0;
            r_pending <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                w_pending <= 1'b1;
            end else if (bvalid && bready) begin
                w_pending <= 1'b0;
            end
            if (arvalid && arready) begin
                r_pending <= 1'b1;
            end else if (rvalid && rready) begin
                r_pending <= 1'b0;
            end
        end
    end

    a_aw_hold: assert property (@(posedge axi4_master) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw dropped or changed before awready");

    a_w_hold: assert property (@(posedge axi4_master) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("w dropped or changed before wready");

    a_ar_hold: assert property (@(posedge axi4_master) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar dropped or changed before arready");

    a_b_after_aw: assert property (@(posedge axi4_master) disable iff (!arst_n)
        bvalid |-> w_pending)
        else $error("bvalid without a write address");

    a_r_after_ar: assert property (@(posedge axi4_master) disable iff (!arst_n)
        rvalid |-> r_pending)
        else $error("rvalid without a read address");

    a_rsp_hold: assert property (@(posedge axi4_master) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp dropped or changed before rsp_ready");

endmodule

bind axi4_master_data dport_axi_assertions i_assertions (
    .axi4_master(axi4_master),
    .arst_n     (arst_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .aw         (aw),
    .wvalid     (wvalid),
    .wready     (wready),
    .w          (w),
    .arvalid    (arvalid),
    .arready    (arready),
    .ar         (ar),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp)
);

// File: sim/dport_axi_tb.sv
module dport_axi_tb;

    import dport_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int MEM_WORDS   = 256;
    localparam int IDX_W       = $clog2(MEM_WORDS);
    localparam int DRIVE_DLY   = 1;
    localparam int TIMEOUT     = 1000;

    logic       axi4_master = 1'b0;
    logic       arst_n;
    logic       req_valid;
    logic       req_ready;
    dport_req_t req;
    logic       rsp_valid;
    logic       rsp_ready;
    dport_rsp_t rsp;

    logic [31:0] lfsr = 32'd94364;
    logic [31:0] model [MEM_WORDS];
    dport_rsp_t  exp_q [$];
    string       name_q [$];
    string       test_name;
    int          ready_mode = 0;
    int          mismatches = 0;
    int          other_errors = 0;

    dport_axi_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .MEM_WORDS  (MEM_WORDS)
    ) i_dut (
        .axi4_master(axi4_master),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp)
    );

    always #4 axi4_master = ~axi4_master;

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Expected response, applied to the model memory in issue order.
    function automatic dport_rsp_t ref_apply(input dport_req_t rq);
        dport_rsp_t  e;
        logic [31:0] idx;
        idx = {2'b00, rq.addr[31:2]};
        e.op    = rq.op;
        e.rdata = '0;
        e.resp  = resp_okay;
        if (idx >= 32'(MEM_WORDS)) begin
            e.resp = resp_slverr;
        end else if (rq.op == op_write) begin
            for (int b = 0; b < 4; b++) begin
                if (rq.mask[b]) begin
                    model[idx[IDX_W-1:0]][8*b +: 8] = rq.wdata[8*b +: 8];
                end
            end
        end else begin
            e.rdata = model[idx[IDX_W-1:0]];
        end
        return e;
    endfunction

    function automatic dport_req_t make_req(input dport_op_e op, input logic [31:0] addr,
                                            input logic [31:0] wdata, input logic [3:0] mask);
        dport_req_t rq;
        rq.op    = op;
        rq.addr  = addr;
        rq.wdata = wdata;
        rq.mask  = mask;
        return rq;
    endfunction

    // About one in eight lands beyond the memory.
    function automatic dport_req_t random_req();
        dport_req_t  rq;
        logic [31:0] idx;
        logic [31:0] low;
        logic [31:0] op_bit;
        logic [31:0] mask_bits;
        op_bit = rand_bits(1);
        idx = rand_bits(8) % 32'(MEM_WORDS);
        if (rand_bits(3) == 32'd0) begin
            idx = idx + 32'(MEM_WORDS);
        end
        low = rand_bits(2);
        mask_bits = rand_bits(4);
        rq.op    = op_bit[0] ? op_write : op_read;
        rq.addr  = {idx[29:0], low[1:0]};
        rq.wdata = rand_bits(32);
        rq.mask  = mask_bits[3:0];
        return rq;
    endfunction

    function automatic string rsp_text(input dport_rsp_t rs);
        return $sformatf("op=%0d rdata=%h resp=%0d", rs.op, rs.rdata, rs.resp);
    endfunction

    task automatic report_and_finish();
        $display("Summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Error: timed out waiting for %s in %s", what, test_name);
        other_errors++;
        report_and_finish();
    endtask

    // Called a drive delay after an edge with req already on the port.
    task automatic wait_accept(input dport_req_t rq);
        int   waited;
        logic done;
        waited = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge axi4_master);
            if (req_ready) begin
                exp_q.push_back(ref_apply(rq));
                name_q.push_back(test_name);
                done = 1'b1;
            end else if (waited == TIMEOUT) begin
                abort_on_timeout("request acceptance");
            end
            waited++;
            @(posedge axi4_master);
            #DRIVE_DLY;
        end
    endtask

    task automatic send(input dport_req_t rq);
        req = rq;
        req_valid = 1'b1;
        wait_accept(rq);
    endtask

    task automatic wait_drain();
        int waited;
        req_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == TIMEOUT) begin
                abort_on_timeout("outstanding responses");
            end
            waited++;
            @(posedge axi4_master);
            #DRIVE_DLY;
        end
    endtask

    // Mode 0 always ready, 1 held low, 2 random stretches.
    initial begin
        int          hold;
        logic        level;
        logic [31:0] bits;
        hold = 0;
        level = 1'b1;
        rsp_ready = 1'b0;
        forever begin
            @(negedge axi4_master);
            if (ready_mode == 2) begin
                if (hold == 0) begin
                    bits = rand_bits(1);
                    level = bits[0];
                    hold = 1 + int'(rand_bits(3));
                end
                hold--;
            end else begin
                level = (ready_mode == 0);
                hold = 0;
            end
            @(posedge axi4_master);
            #DRIVE_DLY;
            rsp_ready = level;
        end
    end

    // Compares every response handshake against the expected queue.
    initial begin
        dport_rsp_t exp;
        dport_rsp_t held_rsp;
        string      name;
        logic       held;
        held = 1'b0;
        held_rsp = '0;
        forever begin
            @(negedge axi4_master);
            if (arst_n) begin
                if (held && (!rsp_valid || rsp !== held_rsp)) begin
                    $display("Error: response changed or dropped while rsp_ready was low");
                    other_errors++;
                end
                held = rsp_valid && !rsp_ready;
                held_rsp = rsp;
                if (rsp_valid && rsp_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("Error: response seen with no request outstanding");
                        other_errors++;
                    end else begin
                        exp = exp_q.pop_front();
                        name = name_q.pop_front();
                        if (rsp !== exp) begin
                            $display("Mismatch %s: expected %s, actual %s",
                                     name, rsp_text(exp), rsp_text(rsp));
                            mismatches++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        dport_req_t rq;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = '0;
        end
        arst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        repeat (2) @(posedge axi4_master);
        #DRIVE_DLY;
        arst_n = 1'b1;

        test_name = "reset_rw";
        @(negedge axi4_master);
        if (!req_ready || rsp_valid) begin
            $display("Error: req_ready low or rsp_valid high after reset");
            other_errors++;
        end
        @(posedge axi4_master);
        #DRIVE_DLY;
        send(make_req(op_write, 32'h40, 32'h1234_5678, 4'hf));
        send(make_req(op_read, 32'h40, 32'h0, 4'h0));
        wait_drain();

        test_name = "partial_mask";
        send(make_req(op_write, 32'h80, 32'h1122_3344, 4'hf));
        send(make_req(op_write, 32'h80, 32'haabb_ccdd, 4'b0101));
        send(make_req(op_write, 32'h80, 32'h99ee_ff00, 4'b1000));
        send(make_req(op_read, 32'h80, 32'h0, 4'h0));
        wait_drain();

        test_name = "out_of_range";
        send(make_req(op_write, 32'h14, 32'hcafe_0005, 4'hf));
        send(make_req(op_read, 32'((MEM_WORDS + 5) * 4), 32'h0, 4'h0));
        send(make_req(op_write, 32'((MEM_WORDS + 5) * 4), 32'hdead_beef, 4'hf));
        send(make_req(op_write, 32'h8000_0014, 32'h0bad_f00d, 4'hf));
        send(make_req(op_read, 32'h14, 32'h0, 4'h0));
        wait_drain();

        test_name = "random_mix";
        for (int n = 0; n < 200; n++) begin
            send(random_req());
        end
        wait_drain();

        test_name = "backpressure";
        ready_mode = 2;
        for (int n = 0; n < 150; n++) begin
            send(random_req());
        end
        ready_mode = 0;
        wait_drain();

        // One request parks in the master, the rest fill the queue.
        test_name = "queue_full";
        ready_mode = 1;
        repeat (2) begin
            @(posedge axi4_master);
            #DRIVE_DLY;
        end
        for (int n = 0; n <= QUEUE_DEPTH; n++) begin
            send(make_req(op_read, 32'(n * 4), 32'h0, 4'h0));
        end
        rq = make_req(op_write, 32'h20, 32'h5a5a_a5a5, 4'hf);
        req = rq;
        req_valid = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge axi4_master);
            if (req_ready) begin
                $display("Error: req_ready high while the queue is full");
                other_errors++;
            end
        end
        @(posedge axi4_master);
        #DRIVE_DLY;
        ready_mode = 0;
        wait_accept(rq);
        wait_drain();

        report_and_finish();
    end

endmodule

// File: sim.f
source/dport_pkg.sv
source/data_req_queue.sv
source/axi4_master_data.sv
source/axi4_sram_slave.sv
source/dport_axi_top.sv
sim/dport_axi_assertions.sv
sim/dport_axi_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, then checks the simulation log.
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module dport_axi_tb \
    -f sim.f > build.log 2>&1 &&
./obj_dir/Vdport_axi_tb > sim.log 2>&1 ;
cat sim.log 2>/dev/null ;
[ -s sim.log ] && grep -q "Test completed successfully" sim.log &&
    ! grep -q "Test failed" sim.log && echo "PASS" && exit 0 ||
    { echo "FAIL: see build.log and sim.log"; exit 1; }
